/* cheat_pkg.sv */
//----------------------------------------------------------------------------
// cheat engine shared definitions
// SDRAM bank request/response bundles and the cheat instruction format
//----------------------------------------------------------------------------

package cheat_pkg;

    // SDRAM word address width
    localparam int sdram_aw = 22;

    // request towards an SDRAM bank, held until ack
    typedef struct packed {
        logic [sdram_aw-1:0] addr;
        logic                rd;
        logic                wr;
        logic [15:0]         din;
        // 1 masks the byte
        logic [1:0]          din_m;
    } sdram_req_t;

    // one-cycle strobes back from the bank
    typedef struct packed {
        logic ack;
        logic dst;
        logic rdy;
    } sdram_rsp_t;

    // cheat opcodes
    typedef enum logic [1:0] {
        op_end     = 2'd0,
        op_addr_hi = 2'd1,
        op_addr_lo = 2'd2,
        op_write   = 2'd3
    } cheat_op_t;

    // 18-bit instruction word, opcode on top
    typedef struct packed {
        cheat_op_t   op;
        logic [15:0] arg;
    } cheat_insn_t;

endpackage

/* cheat_prog_loader.sv */
//----------------------------------------------------------------------------
// cheat program loader
// packs nine programming bytes into four 18-bit instruction words
//----------------------------------------------------------------------------

module cheat_prog_loader #(
    parameter int cheat_aw = 10
) (
    input  logic                   clk,
    input  logic                   prst,
    input  logic                   prog_en,
    input  logic                   prog_wr,
    input  logic [7:0]             prog_data,
    output logic                   wr_en,
    output logic [cheat_aw-1:0]    wr_addr,
    output cheat_pkg::cheat_insn_t wr_data
);
    import cheat_pkg::*;

    logic        last_en;
    logic [3:0]  byte_cnt;
    // bits left over from earlier bytes of the group
    logic [15:0] hold;
    logic        byte_in;

    assign byte_in = prog_en & prog_wr;

    always_ff @(posedge clk) begin
        if (prst) begin
            last_en  <= 1'b0;
            byte_cnt <= 4'd0;
            wr_en    <= 1'b0;
            wr_addr  <= '0;
        end else begin
            last_en <= prog_en;
            wr_en   <= 1'b0;
            if (prog_en && !last_en) begin
                byte_cnt <= 4'd0;
                wr_addr  <= '0;
            end else begin
                if (wr_en) begin
                    wr_addr <= wr_addr + 1'b1;
                end
                if (byte_in) begin
                    byte_cnt <= (byte_cnt == 4'd8) ? 4'd0 : byte_cnt + 4'd1;
                    // bytes 3, 5, 7 and 9 complete a word
                    if (byte_cnt != 4'd0 && !byte_cnt[0]) begin
                        wr_en <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_in) begin
            hold <= {prog_data, hold[15:8]};
            case (byte_cnt)
                4'd2: wr_data <= cheat_insn_t'({prog_data[1:0], hold});
                4'd4: wr_data <= cheat_insn_t'({prog_data[3:0], hold[15:2]});
                4'd6: wr_data <= cheat_insn_t'({prog_data[5:0], hold[15:4]});
                4'd8: wr_data <= cheat_insn_t'({prog_data, hold[15:6]});
                default: ;
            endcase
        end
    end

endmodule

/* cheat_imem.sv */
//----------------------------------------------------------------------------
// cheat instruction memory
// simple dual-port RAM, loader writes and sequencer reads one cycle later
//----------------------------------------------------------------------------

module cheat_imem #(
    parameter int cheat_aw = 10
) (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [cheat_aw-1:0]    wr_addr,
    input  cheat_pkg::cheat_insn_t wr_data,
    input  logic [cheat_aw-1:0]    rd_addr,
    output cheat_pkg::cheat_insn_t rd_data
);
    import cheat_pkg::*;

    localparam int depth = 2 ** cheat_aw;

    cheat_insn_t mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* cheat_sequencer.sv */
//----------------------------------------------------------------------------
// cheat sequencer
// runs the cheat program from pc 0 once per frame at the vblank falling
// edge and writes values to SDRAM, with a per-frame step limit
//----------------------------------------------------------------------------

module cheat_sequencer #(
    parameter int cheat_aw  = 10,
    parameter int max_steps = 64
) (
    input  logic                   clk,
    input  logic                   prst,
    input  logic                   prog_en,
    input  logic                   lvbl,
    output logic [cheat_aw-1:0]    rd_addr,
    input  cheat_pkg::cheat_insn_t rd_data,
    output cheat_pkg::sdram_req_t  seq_req,
    input  cheat_pkg::sdram_rsp_t  seq_rsp
);
    import cheat_pkg::*;

    localparam int sw = $clog2(max_steps + 1);

    typedef enum logic [1:0] {
        idle,
        fetch,
        exec,
        wait_rdy
    } state_t;

    state_t              state;
    logic [cheat_aw-1:0] pc;
    logic [sw-1:0]       step_cnt;
    logic [sdram_aw-1:0] addr;
    logic [15:0]         wdata;
    logic                wr;
    logic                lvbl_last;
    logic                vb_fall;

    assign vb_fall = lvbl_last & ~lvbl;
    assign rd_addr = pc;

    always_comb begin
        seq_req       = '0;
        seq_req.addr  = addr;
        seq_req.wr    = wr;
        seq_req.din   = wdata;
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            state     <= idle;
            pc        <= '0;
            step_cnt  <= '0;
            wr        <= 1'b0;
            lvbl_last <= 1'b0;
        end else begin
            lvbl_last <= lvbl;
            case (state)
                idle: begin
                    if (vb_fall && !prog_en) begin
                        pc       <= '0;
                        step_cnt <= '0;
                        state    <= fetch;
                    end
                end
                fetch: begin
                    // instruction word is read during this cycle
                    if (prog_en || step_cnt == sw'(max_steps)) begin
                        state <= idle;
                    end else begin
                        state <= exec;
                    end
                end
                exec: begin
                    pc       <= pc + 1'b1;
                    step_cnt <= step_cnt + 1'b1;
                    if (prog_en) begin
                        state <= idle;
                    end else begin
                        case (rd_data.op)
                            op_end: state <= idle;
                            op_write: begin
                                wr    <= 1'b1;
                                state <= wait_rdy;
                            end
                            default: state <= fetch;
                        endcase
                    end
                end
                wait_rdy: begin
                    if (seq_rsp.ack) begin
                        wr <= 1'b0;
                    end
                    if (seq_rsp.rdy) begin
                        state <= fetch;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clk) begin
        if (state == exec) begin
            case (rd_data.op)
                op_addr_hi: addr[sdram_aw-1:16] <= rd_data.arg[sdram_aw-17:0];
                op_addr_lo: addr[15:0] <= rd_data.arg;
                op_write:   wdata <= rd_data.arg;
                default: ;
            endcase
        end
        // post-increment once the write is done
        if (state == wait_rdy && seq_rsp.rdy) begin
            addr <= addr + 1'b1;
        end
    end

endmodule

/* cheat_sdram_arbiter.sv */
//----------------------------------------------------------------------------
// SDRAM bank 0 arbiter
// game first when the bank is idle, strobes go back to the owner only
//----------------------------------------------------------------------------

module cheat_sdram_arbiter (
    input  logic                  clk,
    input  logic                  prst,
    input  cheat_pkg::sdram_req_t game_req,
    output cheat_pkg::sdram_rsp_t game_rsp,
    input  cheat_pkg::sdram_req_t seq_req,
    output cheat_pkg::sdram_rsp_t seq_rsp,
    output cheat_pkg::sdram_req_t ba0_req,
    input  cheat_pkg::sdram_rsp_t ba0_rsp
);

    // owner is 1 when the sequencer holds the bank
    logic owner;
    logic busy;
    logic game_act;
    logic seq_act;
    logic sel_seq;

    assign game_act = game_req.rd | game_req.wr;
    assign seq_act  = seq_req.rd | seq_req.wr;

    always_ff @(posedge clk) begin
        if (prst) begin
            owner <= 1'b0;
            busy  <= 1'b0;
        end else begin
            if (ba0_rsp.rdy) begin
                busy <= 1'b0;
            end
            if (!busy) begin
                if (game_act) begin
                    busy  <= 1'b1;
                    owner <= 1'b0;
                end else if (seq_act) begin
                    busy  <= 1'b1;
                    owner <= 1'b1;
                end
            end
        end
    end

    // while idle the would-be winner already drives the bank
    assign sel_seq = busy ? owner : ~game_act;
    assign ba0_req = sel_seq ? seq_req : game_req;

    assign game_rsp = owner ? '0 : ba0_rsp;
    assign seq_rsp  = owner ? ba0_rsp : '0;

endmodule

/* cheat_top.sv */
//----------------------------------------------------------------------------
// cheat engine top level
// program loader, instruction memory, sequencer and bank 0 arbiter
//----------------------------------------------------------------------------

module cheat_top #(
    parameter int cheat_aw  = 10,
    parameter int max_steps = 64
) (
    input  logic                  clk,
    input  logic                  prst,
    input  logic                  lvbl,
    input  logic                  prog_en,
    input  logic                  prog_wr,
    input  logic [7:0]            prog_data,
    input  cheat_pkg::sdram_req_t game_req,
    output cheat_pkg::sdram_rsp_t game_rsp,
    output logic [15:0]           game_data,
    output cheat_pkg::sdram_req_t ba0_req,
    input  cheat_pkg::sdram_rsp_t ba0_rsp,
    input  logic [15:0]           data_read
);
    import cheat_pkg::*;

    logic                wr_en;
    logic [cheat_aw-1:0] wr_addr;
    cheat_insn_t         wr_data;
    logic [cheat_aw-1:0] rd_addr;
    cheat_insn_t         rd_data;
    sdram_req_t          seq_req;
    sdram_rsp_t          seq_rsp;

    // read data only matters to the game
    assign game_data = data_read;

    cheat_prog_loader #(.cheat_aw(cheat_aw)) u_loader (
        .clk       (clk),
        .prst      (prst),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    cheat_imem #(.cheat_aw(cheat_aw)) u_imem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cheat_sequencer #(
        .cheat_aw  (cheat_aw),
        .max_steps (max_steps)
    ) u_seq (
        .clk     (clk),
        .prst    (prst),
        .prog_en (prog_en),
        .lvbl    (lvbl),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .seq_req (seq_req),
        .seq_rsp (seq_rsp)
    );

    cheat_sdram_arbiter u_arb (
        .clk      (clk),
        .prst     (prst),
        .game_req (game_req),
        .game_rsp (game_rsp),
        .seq_req  (seq_req),
        .seq_rsp  (seq_rsp),
        .ba0_req  (ba0_req),
        .ba0_rsp  (ba0_rsp)
    );

endmodule

/* cheat_assertions.sv */
//----------------------------------------------------------------------------
// bank 0 arbiter protocol checks
// ownership and strobe routing checks bound into the arbiter
//----------------------------------------------------------------------------

module cheat_assertions (
    input logic                  clk,
    input logic                  prst,
    input logic                  owner,
    input logic                  busy,
    input cheat_pkg::sdram_req_t game_req,
    input cheat_pkg::sdram_rsp_t game_rsp,
    input cheat_pkg::sdram_req_t seq_req,
    input cheat_pkg::sdram_rsp_t seq_rsp,
    input cheat_pkg::sdram_req_t ba0_req,
    input cheat_pkg::sdram_rsp_t ba0_rsp
);

    // every bank strobe falls inside a held access with a settled owner
    owner_stable: assert property (@(posedge clk) disable iff (prst)
        (|ba0_rsp) |-> (busy && $stable(owner)))
        else $error("bank strobe arrived outside an access or after an owner change");

    // an ack only goes to a requester that is asking for the bank
    strobe_to_owner: assert property (@(posedge clk) disable iff (prst)
        !(game_rsp.ack && !(game_req.rd || game_req.wr)) &&
        !(seq_rsp.ack && !(seq_req.rd || seq_req.wr)))
        else $error("bank ack returned to a requester with no request pending");

    no_rd_wr: assert property (@(posedge clk) disable iff (prst)
        !(ba0_req.rd && ba0_req.wr))
        else $error("bank request has rd and wr high together");

endmodule

/* tb_cheat.sv */
//----------------------------------------------------------------------------
// cheat engine testbench
// loads cheat programs from the input file, runs frames against a small
// SDRAM bank model, checks the logged writes and a game read
//----------------------------------------------------------------------------

module tb_cheat;
    import cheat_pkg::*;

    localparam int frame_cycles = 400;
    localparam int quiet_cycles = 150;
    // word offsets in the input file
    localparam int wr1_at  = 19;
    localparam int game_at = 26;
    localparam int prog2_at = 28;
    localparam int wr2_at  = 47;

    logic        clk = 1'b0;
    logic        prst = 1'b1;
    logic        lvbl = 1'b1;
    logic        prog_en = 1'b0;
    logic        prog_wr = 1'b0;
    logic [7:0]  prog_data = 8'd0;
    sdram_req_t  game_req = '0;
    sdram_rsp_t  game_rsp;
    logic [15:0] game_data;
    sdram_req_t  ba0_req;
    sdram_rsp_t  ba0_rsp = '0;
    logic [15:0] data_read = 16'd0;

    logic [31:0] vec [0:59];
    logic [31:0] lfsr = 32'h6445_2e3b;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          cycles = 0;
    int          limit = 0;
    int          game_strobes = 0;

    // bank model state
    sdram_req_t  req_s = '0;
    sdram_req_t  acc = '0;
    int          bcnt = 0;
    logic [15:0] bank [0:255];
    logic [21:0] log_addr [$];
    logic [15:0] log_data [$];

    always #5 clk = ~clk;

    cheat_top #(.cheat_aw(10), .max_steps(8)) u_cheat_top (.*);

    bind cheat_sdram_arbiter cheat_assertions u_arb_chk (
        .clk      (clk),
        .prst     (prst),
        .owner    (owner),
        .busy     (busy),
        .game_req (game_req),
        .game_rsp (game_rsp),
        .seq_req  (seq_req),
        .seq_rsp  (seq_rsp),
        .ba0_req  (ba0_req),
        .ba0_rsp  (ba0_rsp)
    );

    // request sampled at the clock edge and answered on the falling edge
    always @(posedge clk) begin
        req_s <= ba0_req;
        // bank writes without a game write come from the sequencer
        if (ba0_rsp.ack && ba0_req.wr && !game_req.wr) begin
            log_addr.push_back(ba0_req.addr);
            log_data.push_back(ba0_req.din);
            compare(32'(ba0_req.din_m), 32'd0, "sequencer write mask");
        end
        if (game_rsp.ack || game_rsp.dst || game_rsp.rdy) begin
            game_strobes <= game_strobes + 1;
        end
    end

    // ack 2 cycles after the request and rdy 3 cycles after ack
    always @(negedge clk) begin
        ba0_rsp <= '0;
        if (bcnt == 0) begin
            if (req_s.rd || req_s.wr) begin
                acc  <= req_s;
                bcnt <= 1;
            end
        end else begin
            bcnt <= (bcnt == 4) ? 0 : bcnt + 1;
            case (bcnt)
                1: ba0_rsp.ack <= 1'b1;
                3: begin
                    ba0_rsp.dst <= acc.rd;
                    data_read   <= bank[acc.addr[7:0]];
                end
                4: begin
                    ba0_rsp.rdy <= 1'b1;
                    if (acc.wr) begin
                        bank[acc.addr[7:0]] <= acc.din;
                    end
                end
                default: ;
            endcase
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_program(input int at);
        int n;
        int gap;
        int i;
        n = int'(vec[at]);
        @(negedge clk);
        prog_en = 1'b1;
        for (i = 1; i <= n; i++) begin
            // random gap of 0 to 3 cycles from two LFSR bits
            lfsr = lfsr_next(lfsr);
            gap  = int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
            repeat (gap) @(negedge clk);
            @(negedge clk);
            prog_wr   = 1'b1;
            prog_data = vec[at + i][7:0];
            @(negedge clk);
            prog_wr = 1'b0;
        end
        @(negedge clk);
        prog_en = 1'b0;
    endtask

    task automatic game_read(input int at);
        game_req.addr = vec[at][21:0];
        game_req.rd   = 1'b1;
        do @(posedge clk); while (!game_rsp.ack);
        @(negedge clk);
        game_req.rd = 1'b0;
        do @(posedge clk); while (!game_rsp.dst);
        compare(32'(game_data), vec[at + 1], "game read data");
        do @(posedge clk); while (!game_rsp.rdy);
        @(negedge clk);
    endtask

    // one frame from the vblank falling edge and a quiet window after it
    task automatic run_frame(input int at, input bit with_read);
        int n;
        int first;
        int i;
        n     = int'(vec[at]);
        first = log_addr.size();
        @(negedge clk);
        lvbl = 1'b0;
        if (with_read) begin
            // game read lands while a sequencer write holds the bank
            while (log_addr.size() == first) @(negedge clk);
            game_read(game_at);
        end
        while (log_addr.size() < first + n) @(negedge clk);
        repeat (quiet_cycles) @(negedge clk);
        lvbl = 1'b1;
        compare(32'(log_addr.size() - first), 32'(n), "writes in frame");
        for (i = 0; i < n && first + i < log_addr.size(); i++) begin
            compare(32'(log_addr[first + i]), vec[at + 1 + 2 * i], "write address");
            compare(32'(log_data[first + i]), vec[at + 2 + 2 * i], "write data");
        end
    endtask

    initial begin
        int k;
        $readmemh("cheat_input.txt", vec);
        for (k = 0; k < 256; k++) begin
            bank[k] = {k[7:0], ~k[7:0]};
        end
        limit = int'(vec[0] + vec[prog2_at]) * 5 + 3 * frame_cycles;
        repeat (10) @(negedge clk);
        prst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            compare(32'(game_rsp), 32'd0, "game_rsp after reset");
            compare({30'd0, ba0_req.rd, ba0_req.wr}, 32'd0, "bank rd/wr after reset");
        end
        load_program(0);
        run_frame(wr1_at, 1'b0);
        run_frame(wr1_at, 1'b1);
        load_program(prog2_at);
        run_frame(wr2_at, 1'b0);
        // only the single game read may reach the game
        compare(32'(game_strobes), 32'd3, "game strobes in run");
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* cheat_input.txt */
// cheat engine vectors, hex words: byte count and program bytes, write count and
// addr/data pairs, game read addr and data, second program, its write list
12
12 00 01 D0 F8 EE 3B 8D C4
00 01 56 55 0D 00 00 00 00
// program 1 writes per frame
3
123400 BEEF
123401 1234
120100 5555
// game read address and expected word
42 42BD
// program 2, no op_end
12
01 00 01 00 F8 FF FF FF FF
FF FF FF FF FF FF FF FF FF
// program 2 writes, cut by the step limit
6
010000 FFFF
010001 FFFF
010002 FFFF
010003 FFFF
010004 FFFF
010005 FFFF

/* sim.f */
cheat_pkg.sv
cheat_prog_loader.sv
cheat_imem.sv
cheat_sequencer.sv
cheat_sdram_arbiter.sv
cheat_top.sv
cheat_assertions.sv
tb_cheat.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cheat engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cheat -f sim.f -o tb_cheat_sim
if [ $? -ne 0 ]; then
    echo "error: Verilator build failed"
    exit 1
fi

./obj_dir/tb_cheat_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "error: simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
